// ==== source/rv_core_pkg.sv ====
// rv_core shared types: instruction format views, opcodes and decode selects.
package rv_core_pkg;

  // register-register format.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // immediate format.
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // upper immediate format.
  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // one 32-bit word, three ways to read it.
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } inst_t;

  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // sub.

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {
    A_RS1,
    A_PC,
    A_ZERO
  } a_sel_e;

  typedef enum logic {
    B_RS2,
    B_IMM
  } b_sel_e;

endpackage

// ==== source/inst_intake.sv ====
// Instruction intake: four-phase receiver that tags each word with its pc.
module inst_intake #(
  parameter int                XLEN     = 64,
  parameter logic [XLEN-1:0]   RESET_PC = '0
) (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_inst_req,
  input  rv_core_pkg::inst_t   i_inst,
  input  logic                 i_halt,
  output logic                 o_inst_ack,
  output logic                 o_valid,
  output rv_core_pkg::inst_t   o_inst,
  output logic [XLEN-1:0]      o_pc
);

  logic            ack;
  logic [XLEN-1:0] pc;
  logic            accept;

  // new request seen and the previous handshake fully closed.
  assign accept = i_inst_req & ~ack & ~i_halt;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ack     <= 1'b0;
      o_valid <= 1'b0;
      pc      <= RESET_PC;
    end else begin
      o_valid <= accept; // one pulse per handshake.
      if (accept) begin
        ack <= 1'b1;
        pc  <= pc + XLEN'(4);
      end else if (ack && !i_inst_req) begin
        ack <= 1'b0; // phase four.
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_inst <= i_inst;
      o_pc   <= pc;
    end
  end

  assign o_inst_ack = ack;

  // ack only ever rises in answer to a request.
  a_ack_needs_req : assert property (
    @(posedge i_clk) disable iff (i_reset)
    $rose(o_inst_ack) |-> $past(i_inst_req)
  );

endmodule

// ==== source/inst_decode.sv ====
// Instruction decode: splits a word into operands, immediate and ALU control.
module inst_decode #(
  parameter int XLEN = 64
) (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_valid,
  input  rv_core_pkg::inst_t    i_inst,
  input  logic [XLEN-1:0]       i_pc,
  output logic                  o_valid,
  output logic [4:0]            o_rs1,
  output logic [4:0]            o_rs2,
  output logic [4:0]            o_rd,
  output logic [XLEN-1:0]       o_imm,
  output logic [XLEN-1:0]       o_pc,
  output rv_core_pkg::alu_op_e  o_alu_op,
  output rv_core_pkg::a_sel_e   o_a_sel,
  output rv_core_pkg::b_sel_e   o_b_sel,
  output logic                  o_wen,
  output logic                  o_ebreak,
  output logic                  o_illegal
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] dec_imm;
  alu_op_e         dec_alu_op;
  a_sel_e          dec_a_sel;
  b_sel_e          dec_b_sel;
  logic            dec_wen;
  logic            dec_ebreak;
  logic            dec_illegal;

  // both immediates sign-extend from bit 31.
  assign imm_i = XLEN'($signed(i_inst.i.imm12));
  assign imm_u = XLEN'($signed({i_inst.u.imm20, 12'h000}));

  always_comb begin
    dec_alu_op  = ALU_ADD;
    dec_a_sel   = A_RS1;
    dec_b_sel   = B_IMM;
    dec_imm     = imm_i;
    dec_wen     = 1'b1;
    dec_ebreak  = 1'b0;
    dec_illegal = 1'b0;
    case (i_inst.r.opcode)
      OP_IMM: begin
        case (i_inst.i.funct3)
          3'b000:  dec_alu_op = ALU_ADD;
          3'b010:  dec_alu_op = ALU_SLT;
          3'b011:  dec_alu_op = ALU_SLTU;
          3'b100:  dec_alu_op = ALU_XOR;
          3'b110:  dec_alu_op = ALU_OR;
          3'b111:  dec_alu_op = ALU_AND;
          default: dec_illegal = 1'b1; // immediate shifts.
        endcase
      end
      OP_REG: begin
        dec_b_sel = B_RS2;
        case ({i_inst.r.funct7, i_inst.r.funct3})
          {F7_BASE, 3'b000}: dec_alu_op = ALU_ADD;
          {F7_ALT, 3'b000}:  dec_alu_op = ALU_SUB;
          {F7_BASE, 3'b010}: dec_alu_op = ALU_SLT;
          {F7_BASE, 3'b011}: dec_alu_op = ALU_SLTU;
          {F7_BASE, 3'b100}: dec_alu_op = ALU_XOR;
          {F7_BASE, 3'b110}: dec_alu_op = ALU_OR;
          {F7_BASE, 3'b111}: dec_alu_op = ALU_AND;
          default:           dec_illegal = 1'b1;
        endcase
      end
      OP_LUI: begin
        dec_a_sel = A_ZERO; // 0 + imm.
        dec_imm   = imm_u;
      end
      OP_AUIPC: begin
        dec_a_sel = A_PC;
        dec_imm   = imm_u;
      end
      OP_SYSTEM: begin
        dec_wen = 1'b0;
        // ebreak is the only system word taken; ecall and csr ops are not.
        if (i_inst.i.imm12 == 12'h001 && i_inst.i.funct3 == 3'b000 &&
            i_inst.i.rs1 == 5'd0 && i_inst.i.rd == 5'd0) begin
          dec_ebreak = 1'b1;
        end else begin
          dec_illegal = 1'b1;
        end
      end
      default: dec_illegal = 1'b1;
    endcase
    if (dec_illegal) begin
      dec_wen = 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_rs1     <= i_inst.r.rs1;
      o_rs2     <= i_inst.r.rs2;
      o_rd      <= i_inst.r.rd;
      o_imm     <= dec_imm;
      o_pc      <= i_pc;
      o_alu_op  <= dec_alu_op;
      o_a_sel   <= dec_a_sel;
      o_b_sel   <= dec_b_sel;
      o_wen     <= dec_wen;
      o_ebreak  <= dec_ebreak;
      o_illegal <= dec_illegal;
    end
  end

  a_flags_exclusive : assert property (
    @(posedge i_clk) disable iff (i_reset)
    o_valid |-> !(o_illegal && o_ebreak)
  );

endmodule

// ==== source/reg_file.sv ====
// 32-entry register file with two combinational reads, one write and x0 fixed at zero.
module reg_file #(
  parameter int XLEN = 64
) (
  input  logic            i_clk,
  input  logic            i_reset,
  input  logic [4:0]      i_rs1,
  input  logic [4:0]      i_rs2,
  input  logic            i_we,
  input  logic [4:0]      i_rd,
  input  logic [XLEN-1:0] i_wdata,
  output logic [XLEN-1:0] o_rdata1,
  output logic [XLEN-1:0] o_rdata2
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (i_we && i_rd != 5'd0) begin
      regs[i_rd] <= i_wdata; // x0 writes dropped.
    end
  end

  assign o_rdata1 = regs[i_rs1];
  assign o_rdata2 = regs[i_rs2];

endmodule

// ==== source/exec_stage.sv ====
// Execute stage: operand select, ALU, register write-back and retirement report.
module exec_stage #(
  parameter int XLEN = 64
) (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_valid,
  input  logic [4:0]            i_rs1,
  input  logic [4:0]            i_rs2,
  input  logic [4:0]            i_rd,
  input  logic [XLEN-1:0]       i_imm,
  input  logic [XLEN-1:0]       i_pc,
  input  rv_core_pkg::alu_op_e  i_alu_op,
  input  rv_core_pkg::a_sel_e   i_a_sel,
  input  rv_core_pkg::b_sel_e   i_b_sel,
  input  logic                  i_wen,
  input  logic                  i_ebreak,
  input  logic                  i_illegal,
  output logic                  o_wb_valid,
  output logic                  o_wb_wen,
  output logic [4:0]            o_wb_rd,
  output logic [XLEN-1:0]       o_wb_data,
  output logic                  o_illegal,
  output logic                  o_halt
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] rdata1;
  logic [XLEN-1:0] rdata2;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] result;
  logic            we;

  assign we = i_valid & i_wen;

  reg_file #(
    .XLEN (XLEN)
  ) u_reg_file (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_rs1    (i_rs1),
    .i_rs2    (i_rs2),
    .i_we     (we),
    .i_rd     (i_rd),
    .i_wdata  (result),
    .o_rdata1 (rdata1),
    .o_rdata2 (rdata2)
  );

  always_comb begin
    case (i_a_sel)
      A_RS1:   op_a = rdata1;
      A_PC:    op_a = i_pc;
      default: op_a = '0; // lui.
    endcase
  end

  assign op_b = (i_b_sel == B_IMM) ? i_imm : rdata2;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:  result = op_a + op_b;
      ALU_SUB:  result = op_a - op_b;
      ALU_SLT:  result = XLEN'($signed(op_a) < $signed(op_b));
      ALU_SLTU: result = XLEN'(op_a < op_b);
      ALU_XOR:  result = op_a ^ op_b;
      ALU_OR:   result = op_a | op_b;
      ALU_AND:  result = op_a & op_b;
      default:  result = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_wb_valid <= 1'b0;
      o_wb_wen   <= 1'b0;
      o_illegal  <= 1'b0;
      o_halt     <= 1'b0;
    end else begin
      o_wb_valid <= i_valid;
      o_wb_wen   <= we;
      o_illegal  <= i_valid & i_illegal;
      if (i_valid && i_ebreak) begin
        o_halt <= 1'b1; // sticky until reset.
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_wb_rd   <= i_rd;
      o_wb_data <= i_wen ? result : '0; // zero when nothing is written.
    end
  end

  // intake must stop issuing once halt is up.
  a_no_valid_after_halt : assert property (
    @(posedge i_clk) disable iff (i_reset)
    o_halt |-> !i_valid
  );

endmodule

// ==== source/rv_core_top.sv ====
// rv_core top: intake, decode and execute chained into a three-stage RV64I core.
module rv_core_top #(
  parameter int                XLEN     = 64,
  parameter logic [XLEN-1:0]   RESET_PC = '0
) (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_inst_req,
  input  rv_core_pkg::inst_t   i_inst,
  output logic                 o_inst_ack,
  output logic                 o_wb_valid,
  output logic                 o_wb_wen,
  output logic [4:0]           o_wb_rd,
  output logic [XLEN-1:0]      o_wb_data,
  output logic                 o_illegal,
  output logic                 o_halt
);

  import rv_core_pkg::*;

  logic            in_valid;
  inst_t           in_inst;
  logic [XLEN-1:0] in_pc;

  logic            dec_valid;
  logic [4:0]      dec_rs1;
  logic [4:0]      dec_rs2;
  logic [4:0]      dec_rd;
  logic [XLEN-1:0] dec_imm;
  logic [XLEN-1:0] dec_pc;
  alu_op_e         dec_alu_op;
  a_sel_e          dec_a_sel;
  b_sel_e          dec_b_sel;
  logic            dec_wen;
  logic            dec_ebreak;
  logic            dec_illegal;

  inst_intake #(
    .XLEN     (XLEN),
    .RESET_PC (RESET_PC)
  ) u_intake (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_inst_req (i_inst_req),
    .i_inst     (i_inst),
    .i_halt     (o_halt),
    .o_inst_ack (o_inst_ack),
    .o_valid    (in_valid),
    .o_inst     (in_inst),
    .o_pc       (in_pc)
  );

  inst_decode #(
    .XLEN (XLEN)
  ) u_decode (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_valid   (in_valid),
    .i_inst    (in_inst),
    .i_pc      (in_pc),
    .o_valid   (dec_valid),
    .o_rs1     (dec_rs1),
    .o_rs2     (dec_rs2),
    .o_rd      (dec_rd),
    .o_imm     (dec_imm),
    .o_pc      (dec_pc),
    .o_alu_op  (dec_alu_op),
    .o_a_sel   (dec_a_sel),
    .o_b_sel   (dec_b_sel),
    .o_wen     (dec_wen),
    .o_ebreak  (dec_ebreak),
    .o_illegal (dec_illegal)
  );

  exec_stage #(
    .XLEN (XLEN)
  ) u_exec (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_valid    (dec_valid),
    .i_rs1      (dec_rs1),
    .i_rs2      (dec_rs2),
    .i_rd       (dec_rd),
    .i_imm      (dec_imm),
    .i_pc       (dec_pc),
    .i_alu_op   (dec_alu_op),
    .i_a_sel    (dec_a_sel),
    .i_b_sel    (dec_b_sel),
    .i_wen      (dec_wen),
    .i_ebreak   (dec_ebreak),
    .i_illegal  (dec_illegal),
    .o_wb_valid (o_wb_valid),
    .o_wb_wen   (o_wb_wen),
    .o_wb_rd    (o_wb_rd),
    .o_wb_data  (o_wb_data),
    .o_illegal  (o_illegal),
    .o_halt     (o_halt)
  );

  // retirement follows the ack edge by exactly two cycles.
  a_ack_to_retire : assert property (
    @(posedge i_clk) disable iff (i_reset)
    $rose(o_inst_ack) |-> ##2 o_wb_valid
  );

endmodule

// ==== sim/rv_core_tb.sv ====
// rv_core testbench: sends pattern words over the req/ack handshake and checks each retirement.
module rv_core_tb;

  localparam int          XLEN         = 64;
  localparam int          NUM_PATTERNS = 27;
  localparam int          MAX_CYCLES   = 20 * NUM_PATTERNS + 50;
  localparam int          PROBE_CYCLES = 10;
  localparam logic [31:0] EBREAK_WORD  = 32'h0010_0073;
  localparam logic [31:0] PROBE_WORD   = 32'h0010_0093; // addi x1, x0, 1.

  logic               i_clk;
  logic               i_reset;
  logic               i_inst_req;
  rv_core_pkg::inst_t i_inst;
  logic               o_inst_ack;
  logic               o_wb_valid;
  logic               o_wb_wen;
  logic [4:0]         o_wb_rd;
  logic [XLEN-1:0]    o_wb_data;
  logic               o_illegal;
  logic               o_halt;

  // word [111:80], wen [76], rd [72:68], result [67:4], illegal [0].
  logic [111:0] patterns [NUM_PATTERNS];

  int cycle_count = 0;
  int pass_count  = 0;
  int fail_count  = 0;
  bit test_ok;
  bit halted;

  rv_core_top #(
    .XLEN     (XLEN),
    .RESET_PC (64'h0)
  ) dut (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_inst_req (i_inst_req),
    .i_inst     (i_inst),
    .o_inst_ack (o_inst_ack),
    .o_wb_valid (o_wb_valid),
    .o_wb_wen   (o_wb_wen),
    .o_wb_rd    (o_wb_rd),
    .o_wb_data  (o_wb_data),
    .o_illegal  (o_illegal),
    .o_halt     (o_halt)
  );

  initial begin
    i_clk = 1'b0;
  end

  always #20 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run not finished after %0d cycles, a handshake is stuck", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_field(input string name, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s %s expected %h actual %h", name, field, expected, actual);
      test_ok = 1'b0;
    end
  endtask

  task automatic report_test(input string name);
    if (test_ok) begin
      pass_count++;
      $display("%s ok", name);
    end else begin
      fail_count++;
      $display("%s failed", name);
    end
  endtask

  task automatic check_reset_state();
    test_ok = 1'b1;
    check_field("reset_state", "ack", 64'd0, 64'(o_inst_ack));
    check_field("reset_state", "wb_valid", 64'd0, 64'(o_wb_valid));
    check_field("reset_state", "illegal", 64'd0, 64'(o_illegal));
    check_field("reset_state", "halt", 64'd0, 64'(o_halt));
    report_test("reset_state");
  endtask

  task automatic run_pattern(input int idx);
    logic [111:0] pat;
    logic [31:0]  word;
    logic         exp_wen;
    logic [4:0]   exp_rd;
    logic [63:0]  exp_data;
    logic         exp_ill;
    string        name;
    int           ack_cycle;
    int           latency;
    pat      = patterns[idx];
    word     = pat[111:80];
    exp_wen  = pat[76];
    exp_rd   = pat[72:68];
    exp_data = pat[67:4];
    exp_ill  = pat[0];
    name     = $sformatf("pattern_%0d_%08h", idx, word);
    test_ok  = 1'b1;
    if (word == EBREAK_WORD) begin
      halted = 1'b1; // halt stays up from here on.
    end
    @(negedge i_clk); // idle cycle between handshakes.
    i_inst     = word;
    i_inst_req = 1'b1;
    do begin
      @(negedge i_clk);
    end while (!o_inst_ack);
    ack_cycle  = cycle_count;
    i_inst_req = 1'b0;
    do begin
      @(negedge i_clk);
      assert (!o_inst_ack) else begin
        $display("%s: ack still high a cycle after req was dropped", name);
        test_ok = 1'b0;
      end
    end while (!o_wb_valid);
    latency = cycle_count - ack_cycle;
    assert (latency == 2) else begin
      $display("[FAIL] %s latency expected 2 actual %0d", name, latency);
      test_ok = 1'b0;
    end
    check_field(name, "wen", 64'(exp_wen), 64'(o_wb_wen));
    check_field(name, "rd", 64'(exp_rd), 64'(o_wb_rd));
    if (exp_wen) begin
      check_field(name, "data", exp_data, o_wb_data);
    end
    check_field(name, "illegal", 64'(exp_ill), 64'(o_illegal));
    check_field(name, "halt", 64'(halted), 64'(o_halt));
    report_test(name);
  endtask

  task automatic probe_after_halt();
    bit got_ack;
    got_ack = 1'b0;
    test_ok = 1'b1;
    @(negedge i_clk);
    i_inst     = PROBE_WORD;
    i_inst_req = 1'b1;
    repeat (PROBE_CYCLES) begin
      @(negedge i_clk);
      if (o_inst_ack) begin
        got_ack = 1'b1;
      end
    end
    i_inst_req = 1'b0;
    assert (!got_ack) else begin
      $display("halt_probe: core acknowledged a request while halted");
      test_ok = 1'b0;
    end
    assert (o_halt) else begin
      $display("halt_probe: halt dropped without a reset");
      test_ok = 1'b0;
    end
    report_test("halt_probe");
  endtask

  initial begin
    i_reset    = 1'b1;
    i_inst_req = 1'b0;
    i_inst     = '0;
    halted     = 1'b0;
    test_ok    = 1'b1;
    $readmemh("sim/rv_core_patterns.txt", patterns);
    repeat (4) @(negedge i_clk);
    i_reset = 1'b0;
    check_reset_state();
    if ($isunknown(patterns[NUM_PATTERNS-1]) || patterns[NUM_PATTERNS-1] == '0) begin
      $display("pattern file could not be read or has fewer than %0d lines", NUM_PATTERNS);
      fail_count++;
    end else begin
      for (int idx = 0; idx < NUM_PATTERNS; idx++) begin
        run_pattern(idx);
      end
      probe_after_halt();
    end
    $display("tests done: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/rv_core_patterns.txt ====
// columns: instruction word _ write enable _ rd _ result value _ illegal flag
// pc of each line is 4 times its index; x0..x31 start at zero after reset
// the last line is ebreak and must stay last
00500093_1_01_0000000000000005_0
FFD00113_1_02_FFFFFFFFFFFFFFFD_0
7FF08193_1_03_0000000000000804_0
00112213_1_04_0000000000000001_0
00113293_1_05_0000000000000000_0
FFF0B313_1_06_0000000000000001_0
FFF0C393_1_07_FFFFFFFFFFFFFFFA_0
0F00E413_1_08_00000000000000F5_0
0FF17493_1_09_00000000000000FD_0
00708013_1_00_000000000000000C_0
00100533_1_0A_0000000000000005_0
002085B3_1_0B_0000000000000002_0
40208633_1_0C_0000000000000008_0
401106B3_1_0D_FFFFFFFFFFFFFFF8_0
00112733_1_0E_0000000000000001_0
001137B3_1_0F_0000000000000000_0
0071C833_1_10_FFFFFFFFFFFFF7FE_0
009468B3_1_11_00000000000000FD_0
00717933_1_12_FFFFFFFFFFFFFFF8_0
123459B7_1_13_0000000012345000_0
80000A37_1_14_FFFFFFFF80000000_0
00001A97_1_15_0000000000001054_0
FFFFFB17_1_16_FFFFFFFFFFFFF058_0
001021A3_0_03_0000000000000000_1
00018B93_1_17_0000000000000804_0
00109C13_0_18_0000000000000000_1
00100073_0_00_0000000000000000_0

// ==== rv_core.f ====
source/rv_core_pkg.sv
source/inst_intake.sv
source/inst_decode.sv
source/reg_file.sv
source/exec_stage.sv
source/rv_core_top.sv
sim/rv_core_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the rv_core testbench.
VERILATOR ?= verilator
TOP       := rv_core_tb
FILELIST  := rv_core.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINTFLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
